// ==== rtl/rat.sv ====
`default_nettype none
`include "rename_settings.svh"

// register alias table, architectural reg to rob tag
module rat
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  dec_bundle_t     held,
    input  new_tags_t       new_tags,
    input  retire_bundle_t  retire_in,
    output renamed_bundle_t renamed
);

    // one mapping per architectural register
    tag_ref_t [`RN_AREGS-1:0] map_q;
    // table with this cycle's retires applied
    tag_ref_t [`RN_AREGS-1:0] map_retired;
    // retires plus rename writes, next state
    tag_ref_t [`RN_AREGS-1:0] map_next;

    // lookup for one register of one slot
    // older slots of the same bundle override the table
    function automatic tag_ref_t resolve(
        input areg_t       r,
        input tag_ref_t    base,
        input dec_bundle_t bundle,
        input new_tags_t   tags,
        input int          slot
    );
        tag_ref_t res;
        res = base;
        for (int j = 0; j < slot; j++) begin
            if (bundle[j].valid && bundle[j].dst != '0 && bundle[j].dst == r) begin
                res.valid = 1'b1;
                res.tag   = tags[j];
            end
        end
        // r0 is hardwired, never renamed
        if (r == '0) begin
            res = '0;
        end
        return res;
    endfunction

    // retire first
    // clear only if the entry still points at the retiring tag
    always_comb begin
        map_retired = map_q;
        for (int j = 0; j < `RN_RETIRE_WIDTH; j++) begin
            if (retire_in[j].valid &&
                map_retired[retire_in[j].areg].tag == retire_in[j].tag) begin
                map_retired[retire_in[j].areg] = '0;
            end
        end
    end

    // rename writes on top of the retires
    // later slot wins on a shared dst
    always_comb begin
        map_next = map_retired;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (held[i].valid && held[i].dst != '0) begin
                map_next[held[i].dst].valid = 1'b1;
                map_next[held[i].dst].tag   = new_tags[i];
            end
        end
    end

    // source and old-dst lookup
    // reads the retired table, not map_next
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            renamed[i].valid    = held[i].valid;
            renamed[i].new_tag  = new_tags[i];
            renamed[i].src1     = resolve(held[i].src1, map_retired[held[i].src1],
                                          held, new_tags, i);
            renamed[i].src2     = resolve(held[i].src2, map_retired[held[i].src2],
                                          held, new_tags, i);
            // previous mapping of dst, freed when this one retires
            renamed[i].prev_dst = resolve(held[i].dst, map_retired[held[i].dst],
                                          held, new_tags, i);
        end
    end

    // whole table starts out invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            map_q <= '0;
        end else begin
            map_q <= map_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_intake.sv ====
`default_nettype none
`include "rename_settings.svh"

// input register for the decoded bundle
module rename_intake
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  dec_bundle_t in_bundle,
    input  logic        rob_full,
    output dec_bundle_t held
);

    dec_bundle_t next_held;

    // filter the incoming bundle
    always_comb begin
        next_held = in_bundle;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            // nothing gets in while the rob has no room
            if (rob_full || !in_bundle[i].valid) begin
                next_held[i].valid = 1'b0;
            end
            // idle slots carry no destination
            if (!next_held[i].valid) begin
                next_held[i].dst = '0;
            end
        end
    end

    // sources and dst are payload
    // only the slot valids are cleared on reset
    always_ff @(posedge clk) begin
        held <= next_held;
        if (reset) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                held[i].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_output.sv ====
`default_nettype none
`include "rename_settings.svh"

// output register toward dispatch
module rename_output
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  renamed_bundle_t renamed,
    output renamed_bundle_t out_bundle
);

    renamed_bundle_t clean;

    // idle slots go out all zero
    always_comb begin
        clean = renamed;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (!renamed[i].valid) begin
                clean[i] = '0;
            end
        end
    end

    // one cycle stage
    always_ff @(posedge clk) begin
        if (reset) begin
            out_bundle <= '0;
        end else begin
            out_bundle <= clean;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_pkg.sv ====
`default_nettype none
`include "rename_settings.svh"

package rename_pkg;

    // architectural register index
    typedef logic [$clog2(`RN_AREGS)-1:0] areg_t;

    // rob slot, doubles as the physical tag
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] rob_tag_t;

    // one extra bit so a completely free rob fits
    typedef logic [$clog2(`RN_ROB_DEPTH):0] rob_count_t;

    // decoded instruction from the front end
    typedef struct packed {
        logic  valid;
        areg_t dst;
        areg_t src1;
        areg_t src2;
    } dec_instr_t;

    // valid clear means read the architectural file
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } tag_ref_t;

    // renamed instruction toward dispatch
    typedef struct packed {
        logic     valid;
        rob_tag_t new_tag;
        tag_ref_t src1;
        tag_ref_t src2;
        tag_ref_t prev_dst;
    } renamed_instr_t;

    // commit strobe
    typedef struct packed {
        logic     valid;
        areg_t    areg;
        rob_tag_t tag;
    } retire_t;

    // per-slot bundles, slot 0 is the oldest
    typedef dec_instr_t     [`RN_WIDTH-1:0]        dec_bundle_t;
    typedef renamed_instr_t [`RN_WIDTH-1:0]        renamed_bundle_t;
    typedef retire_t        [`RN_RETIRE_WIDTH-1:0] retire_bundle_t;
    typedef rob_tag_t       [`RN_WIDTH-1:0]        new_tags_t;

endpackage

`default_nettype wire

// ==== rtl/rename_settings.svh ====
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// instructions renamed per cycle
`define RN_WIDTH 2

// architectural register file size
`define RN_AREGS 32

// rob entries, also the number of physical tags
`define RN_ROB_DEPTH 16

// commit strobes per cycle
`define RN_RETIRE_WIDTH 2

`endif

// ==== rtl/rename_top.sv ====
`default_nettype none

// rename stage
// intake, rob allocation, alias table, output register
module rename_top
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  dec_bundle_t     in_bundle,
    input  retire_bundle_t  retire_in,
    output logic            rob_full,
    output renamed_bundle_t out_bundle
);

    dec_bundle_t     held;
    new_tags_t       new_tags;
    renamed_bundle_t renamed;

    // first edge, capture the bundle
    rename_intake u_intake (
        .clk       (clk),
        .reset     (reset),
        .in_bundle (in_bundle),
        .rob_full  (rob_full),
        .held      (held)
    );

    // tags for held, back-pressure to the decoder
    rob_alloc u_rob_alloc (
        .clk       (clk),
        .reset     (reset),
        .held      (held),
        .retire_in (retire_in),
        .new_tags  (new_tags),
        .rob_full  (rob_full)
    );

    // lookup and table update on held
    rat u_rat (
        .clk       (clk),
        .reset     (reset),
        .held      (held),
        .new_tags  (new_tags),
        .retire_in (retire_in),
        .renamed   (renamed)
    );

    // second edge, registered result
    rename_output u_output (
        .clk        (clk),
        .reset      (reset),
        .renamed    (renamed),
        .out_bundle (out_bundle)
    );

endmodule

`default_nettype wire

// ==== rtl/rob_alloc.sv ====
`default_nettype none
`include "rename_settings.svh"

// circular rob bookkeeping and tag assignment
module rob_alloc
    import rename_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  dec_bundle_t    held,
    input  retire_bundle_t retire_in,
    output new_tags_t      new_tags,
    output logic           rob_full
);

    rob_tag_t   tail;
    rob_tag_t   head;
    rob_count_t free_cnt;
    rob_count_t n_alloc;
    rob_count_t n_retire;

    // tags handed out in slot order
    // idle slots consume no entry
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            new_tags[i] = tail + rob_tag_t'(n_alloc);
            if (held[i].valid) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // retires arrive oldest first
    // each one must name the next entry after head
    always_comb begin
        n_retire = '0;
        for (int j = 0; j < `RN_RETIRE_WIDTH; j++) begin
            if (retire_in[j].valid && retire_in[j].tag == head + rob_tag_t'(n_retire)) begin
                n_retire = n_retire + 1'b1;
            end
        end
    end

    // room left after this bundle
    // a full next bundle needs RN_WIDTH entries
    assign rob_full = (free_cnt - n_alloc) < rob_count_t'(`RN_WIDTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            tail     <= '0;
            head     <= '0;
            free_cnt <= rob_count_t'(`RN_ROB_DEPTH);
        end else begin
            // pointers wrap on their own at the depth
            tail     <= tail + rob_tag_t'(n_alloc);
            head     <= head + rob_tag_t'(n_retire);
            free_cnt <= free_cnt - n_alloc + n_retire;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== tb.f ====
+incdir+rtl
rtl/rename_pkg.sv
rtl/rename_intake.sv
rtl/rob_alloc.sv
rtl/rat.sv
rtl/rename_output.sv
rtl/rename_top.sv
tb/tb_clock.sv
tb/rename_assert.sv
tb/rename_tb.sv

// ==== tb/rename_assert.sv ====
`default_nettype none
`include "rename_settings.svh"

// shadow rename model bound into rename_top
// built from the top-level ports only
module rename_assert
    import rename_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input dec_bundle_t     in_bundle,
    input retire_bundle_t  retire_in,
    input logic            rob_full,
    input renamed_bundle_t out_bundle
);

    timeunit 1ns;
    timeprecision 100ps;

    // assertion failures so far
    int unsigned fail_count = 0;

    tag_ref_t [`RN_AREGS-1:0] sh_map;
    dec_bundle_t              sh_held;
    rob_tag_t                 sh_tail;
    rob_count_t               sh_free;
    renamed_bundle_t          exp_out;
    logic                     exp_full;

    always @(posedge clk) begin : shadow
        tag_ref_t [`RN_AREGS-1:0] m;
        dec_bundle_t              acc;
        renamed_bundle_t          exp;
        rob_tag_t                 t;
        int                       n_alloc;
        int                       n_ret;
        if (reset) begin
            sh_map  <= '0;
            sh_held <= '0;
            sh_tail <= '0;
            sh_free <= rob_count_t'(`RN_ROB_DEPTH);
            exp_out <= '0;
        end else begin
            // slots offered while the rob has room
            acc = '0;
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (in_bundle[i].valid && !rob_full) begin
                    acc[i] = in_bundle[i];
                end
            end
            // retires at this edge come before the renames
            m     = sh_map;
            n_ret = 0;
            for (int j = 0; j < `RN_RETIRE_WIDTH; j++) begin
                if (retire_in[j].valid) begin
                    n_ret++;
                    if (m[retire_in[j].areg].valid &&
                        m[retire_in[j].areg].tag == retire_in[j].tag) begin
                        m[retire_in[j].areg] = '0;
                    end
                end
            end
            // slot by slot, so slot 1 sees what slot 0 wrote
            exp     = '0;
            t       = sh_tail;
            n_alloc = 0;
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (sh_held[i].valid) begin
                    exp[i].valid    = 1'b1;
                    exp[i].new_tag  = t;
                    // r0 is never written, so it reads invalid
                    exp[i].src1     = m[sh_held[i].src1];
                    exp[i].src2     = m[sh_held[i].src2];
                    exp[i].prev_dst = m[sh_held[i].dst];
                    if (sh_held[i].dst != '0) begin
                        m[sh_held[i].dst].valid = 1'b1;
                        m[sh_held[i].dst].tag   = t;
                    end
                    t = t + 1'b1;
                    n_alloc++;
                end
            end
            sh_held <= acc;
            sh_map  <= m;
            sh_tail <= t;
            sh_free <= sh_free - rob_count_t'(n_alloc) + rob_count_t'(n_ret);
            exp_out <= exp;
        end
    end

    // room left once the held slots take their entries
    always_comb begin
        int pending;
        pending = 0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (sh_held[i].valid) begin
                pending++;
            end
        end
        exp_full = (int'(sh_free) - pending) < `RN_WIDTH;
    end

    a_rob_full: assert property (@(posedge clk) disable iff (reset) rob_full == exp_full)
        else begin
            fail_count++;
            $error("** Error at %0t: rob_full expected %b got %b",
                   $time, $sampled(exp_full), $sampled(rob_full));
        end

    for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_slot
        // two-edge latency and rob order of the tags
        a_new_tag: assert property (@(posedge clk) disable iff (reset)
            {out_bundle[i].valid, out_bundle[i].new_tag} ==
            {exp_out[i].valid, exp_out[i].new_tag})
            else begin
                fail_count++;
                $error("** Error at %0t: out_bundle[%0d] valid/new_tag expected %b/%h got %b/%h",
                       $time, i, $sampled(exp_out[i].valid), $sampled(exp_out[i].new_tag),
                       $sampled(out_bundle[i].valid), $sampled(out_bundle[i].new_tag));
            end
        // lookups, forwarding and retire clearing
        a_refs: assert property (@(posedge clk) disable iff (reset)
            {out_bundle[i].src1, out_bundle[i].src2, out_bundle[i].prev_dst} ==
            {exp_out[i].src1, exp_out[i].src2, exp_out[i].prev_dst})
            else begin
                fail_count++;
                $error(
                    "** Error at %0t: out_bundle[%0d] src1/src2/prev_dst exp %h/%h/%h got %h/%h/%h",
                    $time, i, $sampled(exp_out[i].src1), $sampled(exp_out[i].src2),
                    $sampled(exp_out[i].prev_dst), $sampled(out_bundle[i].src1),
                    $sampled(out_bundle[i].src2), $sampled(out_bundle[i].prev_dst));
            end
    end

endmodule

`default_nettype wire

// ==== tb/rename_tb.sv ====
`default_nettype none
`include "rename_settings.svh"

// stimulus and retire bookkeeping for the rename stage
module rename_tb
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_CYCLES  = 150;
    localparam int FILL_CYCLES  = 14;
    localparam int DRAIN_CYCLES = 14;
    // reset, first bundle (about 4), the phases, 4 to empty the pipe
    localparam int STIM_CYCLES  = RESET_CYCLES + 4 + RAND_CYCLES + FILL_CYCLES
                                  + DRAIN_CYCLES + 4;

    // accepted instruction waiting to retire
    typedef struct packed {
        areg_t       areg;
        rob_tag_t    tag;
        logic [31:0] ready_cyc;
    } pending_t;

    logic            clk;
    logic            reset;
    dec_bundle_t     in_bundle;
    retire_bundle_t  retire_in;
    logic            rob_full;
    renamed_bundle_t out_bundle;

    logic [31:0] lcg_state;
    pending_t    outstanding[$];
    rob_tag_t    next_tag;
    int unsigned cycle        = 0;
    int unsigned reset_errors = 0;
    int unsigned timeouts     = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    rename_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .in_bundle  (in_bundle),
        .retire_in  (retire_in),
        .rob_full   (rob_full),
        .out_bundle (out_bundle)
    );

    bind rename_top rename_assert u_assert (
        .clk        (clk),
        .reset      (reset),
        .in_bundle  (in_bundle),
        .retire_in  (retire_in),
        .rob_full   (rob_full),
        .out_bundle (out_bundle)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // small register range, so renames collide often
    function automatic areg_t pick_reg();
        return areg_t'((lcg_next() >> 12) % 8);
    endfunction

    task automatic expect_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            reset_errors++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // record an accepted slot with its tag in rob order
    task automatic note_accepted(input areg_t dst, input logic [31:0] ready);
        pending_t p;
        p.areg      = dst;
        p.tag       = next_tag;
        p.ready_cyc = ready;
        outstanding.push_back(p);
        next_tag++;
    endtask

    // idle after reset, then one bundle whose sources were never written
    task automatic check_reset_state();
        dec_bundle_t b;
        @(negedge clk);
        for (int i = 0; i < `RN_WIDTH; i++) begin
            expect_bit($sformatf("out_bundle[%0d].valid", i), out_bundle[i].valid, 1'b0);
        end
        expect_bit("rob_full", rob_full, 1'b0);
        b = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            b[i].valid = 1'b1;
            b[i].dst   = areg_t'(3 * i + 1);
            b[i].src1  = areg_t'(3 * i + 2);
            b[i].src2  = areg_t'(3 * i + 3);
            note_accepted(b[i].dst, 32'd0);
        end
        @(posedge clk);
        in_bundle <= b;
        @(posedge clk);
        in_bundle <= '0;
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < `RN_WIDTH; i++) begin
            expect_bit($sformatf("out_bundle[%0d].valid", i), out_bundle[i].valid, 1'b1);
            expect_bit($sformatf("out_bundle[%0d].src1.valid", i), out_bundle[i].src1.valid, 1'b0);
            expect_bit($sformatf("out_bundle[%0d].src2.valid", i), out_bundle[i].src2.valid, 1'b0);
            expect_bit($sformatf("out_bundle[%0d].prev_dst.valid", i),
                       out_bundle[i].prev_dst.valid, 1'b0);
        end
    endtask

    // one clock of traffic
    // bookkeeping at the falling edge, drive at the next rising edge
    task automatic run_cycle(input int issue_pct, input int retire_pct);
        dec_bundle_t    b;
        retire_bundle_t r;
        int             nr;
        @(negedge clk);
        cycle++;
        // rob_full now decides whether the bundle on in_bundle gets in
        if (!rob_full) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (in_bundle[i].valid) begin
                    note_accepted(in_bundle[i].dst, cycle + 1);
                end
            end
        end
        // oldest first, slot 1 only behind slot 0
        r  = '0;
        nr = 0;
        for (int j = 0; j < `RN_RETIRE_WIDTH; j++) begin
            if (nr == j && outstanding.size() > 0 && outstanding[0].ready_cyc <= cycle &&
                ((lcg_next() >> 8) % 100) < retire_pct) begin
                r[j].valid = 1'b1;
                r[j].areg  = outstanding[0].areg;
                r[j].tag   = outstanding[0].tag;
                void'(outstanding.pop_front());
                nr++;
            end
        end
        b = '0;
        if (!rob_full) begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                b[i].valid = ((lcg_next() >> 8) % 100) < issue_pct;
                b[i].dst   = pick_reg();
                b[i].src1  = pick_reg();
                b[i].src2  = pick_reg();
            end
        end
        @(posedge clk);
        in_bundle <= b;
        retire_in <= r;
    endtask

    task automatic finish_run();
        int unsigned assert_errors;
        assert_errors = u_dut.u_assert.fail_count;
        $display("assertion failures %0d, reset state failures %0d, timeouts %0d",
                 assert_errors, reset_errors, timeouts);
        if (assert_errors + reset_errors + timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin : stimulus
        lcg_state = 32'h8be5;
        next_tag  = '0;
        reset     = 1'b1;
        in_bundle = '0;
        retire_in = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        // mixed issue and retire
        repeat (RAND_CYCLES) run_cycle(60, 50);
        // full bundles with no retires, rob runs full
        repeat (FILL_CYCLES) run_cycle(100, 0);
        // retire everything that is left
        repeat (DRAIN_CYCLES) run_cycle(0, 100);
        repeat (4) run_cycle(0, 0);
        // the last rising edge's assertions have all fired by now
        @(negedge clk);
        finish_run();
    end

    initial begin : watchdog
        #((STIM_CYCLES + 20) * CLK_NS);
        timeouts++;
        $display("watchdog expired before the stimulus finished");
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

// free-running testbench clock, 8 ns period
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // half of the 8 ns period
    localparam real HALF_NS = 4.0;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

endmodule

`default_nettype wire
